// File: design/snes_pkg.sv
package snes_pkg;

  typedef logic [23:0] snes_addr_t;  // SNES bus or PSRAM byte address
  typedef logic [7:0]  byte_t;

  typedef enum logic {
    MAP_LOROM = 1'b0,
    MAP_HIROM = 1'b1
  } mapper_e;

  // console bus after the oversampling filters
  typedef struct packed {
    snes_addr_t addr;
    byte_t      data;
    logic       read_n;
    logic       write_n;
    logic       cpu_clk;
    logic       romsel_n;
  } snes_bus_t;

  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;  // cpu clock rising
    logic pulse_end;    // idle cycle, no read and no write
  } snes_strobes_t;

  typedef struct packed {
    logic       rrq;
    logic       wrq;
    snes_addr_t addr;
    byte_t      wdata;
  } mcu_req_t;

  typedef struct packed {
    snes_addr_t rom_addr;
    logic       rom_hit;
    logic       is_rom;
    logic       is_saveram;
  } map_result_t;

  localparam snes_addr_t SAVERAM_BASE = 24'hE00000;  // save RAM sits at the top of PSRAM
  localparam int         SYNC_DEPTH   = 7;

endpackage

// File: design/sample_pipe.sv
`timescale 1ns/1ps

module sample_pipe #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 7
) (
  input  logic                 CLK2,
  input  logic                 arst_n,
  input  payload_t             in,
  output payload_t [DEPTH-1:0] taps,
  output payload_t             filtered
);

  // filter taps 4 and 5 must exist
  if (DEPTH < 6) begin : g_depth_check
    $error("sample_pipe needs DEPTH of at least 6");
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      taps <= '0;
    end else begin
      taps <= {taps[DEPTH-2:0], in};  // tap 0 is the newest sample
    end
  end

  // a bit has to be high in two samples in a row
  // drops single-sample glitches towards 1
  assign filtered = payload_t'(taps[5] & taps[4]);

endmodule

// File: design/snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync (
  input  logic                    CLK2,
  input  logic                    arst_n,
  input  snes_pkg::snes_addr_t    addr_in,
  input  snes_pkg::byte_t         data_in,
  input  logic                    read_n_in,
  input  logic                    write_n_in,
  input  logic                    cpu_clk_in,
  input  logic                    romsel_n_in,
  output snes_pkg::snes_bus_t     bus,
  output snes_pkg::snes_strobes_t strobes
);
  import snes_pkg::*;

  logic [7:0] read_hist;
  logic [7:0] write_hist;
  logic [7:0] cpu_clk_hist;
  logic [7:0] romsel_hist;
  logic [7:0] pulse_hist;
  logic       pulse_in;
  snes_addr_t addr_f;
  byte_t      data_f;

  assign pulse_in = read_n_in & write_n_in & ~cpu_clk_in;  // clock low, bus idle

  //////////////////////////////////////////////////
  // control line histories, bit 0 newest

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      read_hist    <= '1;
      write_hist   <= '1;
      cpu_clk_hist <= '0;
      romsel_hist  <= '1;
      pulse_hist   <= '1;
    end else begin
      read_hist    <= {read_hist[6:0], read_n_in};
      write_hist   <= {write_hist[6:0], write_n_in};
      cpu_clk_hist <= {cpu_clk_hist[6:0], cpu_clk_in};
      romsel_hist  <= {romsel_hist[6:0], romsel_n_in};
      pulse_hist   <= {pulse_hist[6:0], pulse_in};
    end
  end

  sample_pipe #(.payload_t(snes_addr_t), .DEPTH(SYNC_DEPTH)) u_addr_pipe (
    .CLK2     (CLK2),
    .arst_n   (arst_n),
    .in       (addr_in),
    .taps     (),
    .filtered (addr_f)
  );

  sample_pipe #(.payload_t(byte_t), .DEPTH(SYNC_DEPTH)) u_data_pipe (
    .CLK2     (CLK2),
    .arst_n   (arst_n),
    .in       (data_in),
    .taps     (),
    .filtered (data_f)
  );

  always_comb begin
    bus.addr     = addr_f;
    bus.data     = data_f;
    bus.read_n   = read_hist[2] & read_hist[1];
    bus.write_n  = write_hist[2] & write_hist[1];
    bus.cpu_clk  = cpu_clk_hist[2] & cpu_clk_hist[1];
    bus.romsel_n = romsel_hist[5] & romsel_hist[4];  // aligned with the slow address pipe
  end

  //////////////////////////////////////////////////
  // edge strobes, one cycle each

  always_comb begin
    strobes.rd_start    = (read_hist[6:1] == 6'b111110);
    strobes.rd_end      = (read_hist[6:1] == 6'b000001);
    strobes.wr_end      = (write_hist[6:1] == 6'b000001);
    strobes.cycle_start = (cpu_clk_hist[6:1] == 6'b000001);
    strobes.pulse_end   = (pulse_hist[6:1] == 6'b000011);  // two high samples confirm it
  end

endmodule

// File: design/rom_map.sv
`timescale 1ns/1ps

module rom_map (
  input  snes_pkg::mapper_e     mapper,
  input  snes_pkg::snes_addr_t  rom_mask,
  input  snes_pkg::snes_addr_t  saveram_mask,
  input  snes_pkg::snes_bus_t   bus,
  output snes_pkg::map_result_t map
);
  import snes_pkg::*;

  logic       is_rom;
  logic       is_saveram;
  snes_addr_t rom_off;
  snes_addr_t sram_off;

  always_comb begin
    case (mapper)
      MAP_HIROM: begin
        // upper half of every bank, plus banks 40-7d and c0-ff whole
        is_rom     = bus.addr[22] | bus.addr[15];
        is_saveram = (bus.addr[22:21] == 2'b01) && (bus.addr[15:13] == 3'b011);
        rom_off    = {2'b00, bus.addr[21:0]} & rom_mask;
        sram_off   = {6'h00, bus.addr[20:16], bus.addr[12:0]} & saveram_mask;
      end
      default: begin
        // 32k pages at 8000-ffff, save RAM in banks 70-7d below 8000
        is_rom     = bus.addr[15];
        is_saveram = (bus.addr[23:16] >= 8'h70) && (bus.addr[23:16] <= 8'h7D)
                     && !bus.addr[15];
        rom_off    = {2'b00, bus.addr[22:16], bus.addr[14:0]} & rom_mask;
        sram_off   = {4'h0, bus.addr[20:16], bus.addr[14:0]} & saveram_mask;
      end
    endcase
  end

  always_comb begin
    map.is_rom     = is_rom;
    map.is_saveram = is_saveram;
    map.rom_hit    = is_rom | is_saveram;
    map.rom_addr   = is_saveram ? (SAVERAM_BASE + sram_off) : rom_off;
  end

endmodule

// File: design/snes_liveness.sv
`timescale 1ns/1ps

module snes_liveness #(
  parameter int DEAD_TIMEOUT = 80000
) (
  input  logic                CLK2,
  input  logic                arst_n,
  input  snes_pkg::snes_bus_t bus,
  output logic                dead,
  output logic                reset_strobe
);

  logic [17:0] dead_cnt;  // cycles since the cpu clock was last high

  if (DEAD_TIMEOUT >= 2**18 - 1) begin : g_timeout_check
    $error("DEAD_TIMEOUT does not fit the 18-bit counter");
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt <= '0;
    end else if (bus.cpu_clk) begin
      dead_cnt <= '0;
    end else if (!(&dead_cnt)) begin
      dead_cnt <= dead_cnt + 18'd1;  // saturates
    end
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead         <= 1'b1;  // no console until its clock is seen
      reset_strobe <= 1'b0;
    end else begin
      reset_strobe <= 1'b0;
      if (bus.cpu_clk) begin
        dead         <= 1'b0;
        reset_strobe <= dead;  // console came back
      end else if (dead_cnt > DEAD_TIMEOUT) begin
        dead <= 1'b1;
      end
    end
  end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int ROM_CYCLE_LEN = 6
) (
  input  logic                    CLK2,
  input  logic                    arst_n,
  input  snes_pkg::mcu_req_t      mcu,
  input  snes_pkg::snes_strobes_t strobes,
  input  snes_pkg::snes_bus_t     bus,
  input  snes_pkg::map_result_t   map,
  input  logic                    dead,
  input  snes_pkg::byte_t         rom_rdata,
  output logic                    mcu_rdy,
  output snes_pkg::byte_t         mcu_rdata,
  output snes_pkg::snes_addr_t    acc_addr,
  output logic                    mcu_hit,
  output logic                    mcu_we_hit
);

  localparam int DLY_W = $clog2(ROM_CYCLE_LEN + 2);

  typedef enum logic [4:0] {
    ST_IDLE    = 5'b00001,
    ST_RD_ADDR = 5'b00010,
    ST_RD_END  = 5'b00100,
    ST_WR_ADDR = 5'b01000,
    ST_WR_END  = 5'b10000
  } state_e;

  state_e           state;
  logic [DLY_W-1:0] delay;
  logic             rd_pend;
  logic             wr_pend;
  logic             free_strobe;
  logic             free_slot;
  logic             revive;

  //////////////////////////////////////////////////
  // free slots on the PSRAM

  // cpu cycle started on something outside ROM and save RAM
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= strobes.cycle_start & ~map.rom_hit;
    end
  end

  assign free_slot = strobes.pulse_end | free_strobe | dead;  // dead console, PSRAM is ours
  assign revive    = dead & bus.cpu_clk;

  //////////////////////////////////////////////////
  // request latch

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu.rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu.wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (state == ST_RD_END || state == ST_WR_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  // one data register, write byte while writing, read byte after a read
  always_ff @(posedge CLK2) begin
    if (mcu.rrq || mcu.wrq) begin
      acc_addr <= mcu.addr;
    end
    if (mcu.wrq) begin
      mcu_rdata <= mcu.wdata;
    end else if (state == ST_RD_ADDR) begin
      mcu_rdata <= rom_rdata;  // last sample wins, PSRAM settled by then
    end
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (revive) begin
      state <= ST_IDLE;  // console woke up mid access, pending flag retries it
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot && rd_pend) begin
            state <= ST_RD_ADDR;
            delay <= DLY_W'(ROM_CYCLE_LEN);
          end else if (free_slot && wr_pend) begin
            state <= ST_WR_ADDR;
            delay <= DLY_W'(ROM_CYCLE_LEN);
          end
        end
        ST_RD_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_RD_END;
        end
        ST_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_WR_END;
        end
        default: state <= ST_IDLE;  // both end states
      endcase
    end
  end

  assign mcu_hit    = (state != ST_IDLE);
  assign mcu_we_hit = (state == ST_WR_ADDR);

  a_no_req_busy: assert property (@(posedge CLK2) disable iff (!arst_n)
    !mcu_rdy |-> !(mcu.rrq || mcu.wrq))
    else $error("MCU request issued while the previous one is still busy");

  a_state_onehot: assert property (@(posedge CLK2) disable iff (!arst_n)
    $onehot(state))
    else $error("arbiter state is not one-hot");

endmodule

// File: design/rom_port.sv
`timescale 1ns/1ps

module rom_port (
  input  snes_pkg::snes_bus_t   bus,
  input  snes_pkg::map_result_t map,
  input  logic                  mcu_hit,
  input  logic                  mcu_we_hit,
  input  snes_pkg::snes_addr_t  acc_addr,
  input  snes_pkg::byte_t       mcu_wdata,
  input  logic [15:0]           rom_data_in,
  output logic [22:0]           rom_addr,
  output logic [15:0]           rom_data_out,
  output logic [1:0]            rom_data_oe,
  output logic                  rom_we_n,
  output logic                  rom_bhe_n,
  output logic                  rom_ble_n,
  output snes_pkg::byte_t       rom_rdata,
  output snes_pkg::byte_t       snes_data_out,
  output logic                  snes_data_oe,
  output logic                  snes_databus_oe_n,
  output logic                  snes_databus_dir
);
  import snes_pkg::*;

  snes_addr_t psram_addr;
  byte_t      wr_byte;
  logic       lane_lo;   // 1 = low byte lane
  logic       snes_wr;
  logic       drive;

  assign psram_addr = mcu_hit ? acc_addr : map.rom_addr;
  assign rom_addr   = psram_addr[23:1];
  assign lane_lo    = psram_addr[0];
  assign rom_bhe_n  = lane_lo;
  assign rom_ble_n  = ~lane_lo;

  // PSRAM write side
  assign snes_wr      = map.rom_hit & ~bus.write_n;
  assign wr_byte      = snes_wr ? bus.data : mcu_wdata;
  assign drive        = snes_wr | mcu_we_hit;
  assign rom_data_out = {wr_byte, wr_byte};  // oe picks the lane
  assign rom_data_oe  = drive ? {~lane_lo, lane_lo} : 2'b00;
  assign rom_we_n     = (map.is_saveram & bus.cpu_clk) ? bus.write_n : ~mcu_we_hit;

  assign rom_rdata     = lane_lo ? rom_data_in[7:0] : rom_data_in[15:8];
  assign snes_data_out = rom_rdata;
  assign snes_data_oe  = ~bus.read_n & map.rom_hit;

  // transceiver, dir 1 = FPGA to console
  assign snes_databus_dir  = ~bus.read_n;
  assign snes_databus_oe_n = ~(map.rom_hit & ~(map.is_rom & bus.romsel_n)
                               & ~(bus.read_n & bus.write_n));

  // a console save RAM write must not land inside an MCU read slot
  always_comb begin
    a_no_we_in_read: assert final (!(mcu_hit && !mcu_we_hit) || rom_we_n)
      else $error("PSRAM write strobe during an MCU read access");
  end

endmodule

// File: design/cart_main.sv
`timescale 1ns/1ps

module cart_main #(
  parameter int ROM_CYCLE_LEN = 6,
  parameter int DEAD_TIMEOUT  = 80000
) (
  input  logic                  CLK2,
  input  logic                  arst_n,
  input  snes_pkg::snes_addr_t  snes_addr_in,
  input  snes_pkg::byte_t       snes_data_in,
  input  logic                  snes_read_n_in,
  input  logic                  snes_write_n_in,
  input  logic                  snes_cpu_clk_in,
  input  logic                  snes_romsel_n_in,
  output snes_pkg::byte_t       snes_data_out,
  output logic                  snes_data_oe,
  output logic                  snes_databus_oe_n,
  output logic                  snes_databus_dir,
  input  snes_pkg::mapper_e     mapper,
  input  snes_pkg::snes_addr_t  rom_mask,
  input  snes_pkg::snes_addr_t  saveram_mask,
  input  snes_pkg::mcu_req_t    mcu,
  output logic                  mcu_rdy,
  output snes_pkg::byte_t       mcu_rdata,
  output logic [22:0]           rom_addr,
  input  logic [15:0]           rom_data_in,
  output logic [15:0]           rom_data_out,
  output logic [1:0]            rom_data_oe,
  output logic                  rom_we_n,
  output logic                  rom_bhe_n,
  output logic                  rom_ble_n
);
  import snes_pkg::*;

  snes_bus_t     bus;
  snes_strobes_t strobes;
  map_result_t   map;
  logic          dead;
  logic          mcu_hit;
  logic          mcu_we_hit;
  snes_addr_t    acc_addr;
  byte_t         rom_rdata;

  snes_bus_sync u_sync (
    .CLK2        (CLK2),
    .arst_n      (arst_n),
    .addr_in     (snes_addr_in),
    .data_in     (snes_data_in),
    .read_n_in   (snes_read_n_in),
    .write_n_in  (snes_write_n_in),
    .cpu_clk_in  (snes_cpu_clk_in),
    .romsel_n_in (snes_romsel_n_in),
    .bus         (bus),
    .strobes     (strobes)
  );

  rom_map u_map (
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .bus          (bus),
    .map          (map)
  );

  snes_liveness #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) u_live (
    .CLK2         (CLK2),
    .arst_n       (arst_n),
    .bus          (bus),
    .dead         (dead),
    .reset_strobe ()
  );

  mem_arbiter #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN)) u_arb (
    .CLK2       (CLK2),
    .arst_n     (arst_n),
    .mcu        (mcu),
    .strobes    (strobes),
    .bus        (bus),
    .map        (map),
    .dead       (dead),
    .rom_rdata  (rom_rdata),
    .mcu_rdy    (mcu_rdy),
    .mcu_rdata  (mcu_rdata),
    .acc_addr   (acc_addr),
    .mcu_hit    (mcu_hit),
    .mcu_we_hit (mcu_we_hit)
  );

  rom_port u_port (
    .bus               (bus),
    .map               (map),
    .mcu_hit           (mcu_hit),
    .mcu_we_hit        (mcu_we_hit),
    .acc_addr          (acc_addr),
    .mcu_wdata         (mcu_rdata),  // holds the write byte during a write
    .rom_data_in       (rom_data_in),
    .rom_addr          (rom_addr),
    .rom_data_out      (rom_data_out),
    .rom_data_oe       (rom_data_oe),
    .rom_we_n          (rom_we_n),
    .rom_bhe_n         (rom_bhe_n),
    .rom_ble_n         (rom_ble_n),
    .rom_rdata         (rom_rdata),
    .snes_data_out     (snes_data_out),
    .snes_data_oe      (snes_data_oe),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_databus_dir  (snes_databus_dir)
  );

endmodule

// File: testbench/tb_tasks.svh
//////////////////////////////////////////////////
// checking

task automatic check_value(input string test, input logic [31:0] expected,
                           input logic [31:0] actual);
  assert (expected === actual) else begin
    $display("CHECK FAILED %s expected %0h actual %0h", test, expected, actual);
    value_errors++;
  end
endtask

//////////////////////////////////////////////////
// SNES bus cycles

task automatic snes_read(input string test, input snes_addr_t addr, input byte_t expected);
  @(posedge CLK2);
  snes_addr_in     <= addr;
  snes_romsel_n_in <= !(addr[22] | addr[15]);
  snes_cpu_clk_in  <= 1'b0;
  snes_read_n_in   <= 1'b1;
  repeat (LOW_CYCLES) @(posedge CLK2);
  snes_cpu_clk_in <= 1'b1;
  repeat (2) @(posedge CLK2);
  snes_read_n_in <= 1'b0;
  repeat (20) @(posedge CLK2);
  @(negedge CLK2);  // data settled while read_n is still low
  check_value({test, " oe"}, 1, snes_data_oe);
  check_value({test, " dir"}, 1, snes_databus_dir);
  check_value({test, " bus oe_n"}, 0, snes_databus_oe_n);
  check_value(test, expected, snes_data_out);
  @(posedge CLK2);
  snes_read_n_in  <= 1'b1;
  snes_cpu_clk_in <= 1'b0;
endtask

task automatic snes_write(input string test, input snes_addr_t addr, input byte_t data);
  @(posedge CLK2);
  snes_addr_in     <= addr;
  snes_data_in     <= data;
  snes_romsel_n_in <= 1'b1;
  snes_cpu_clk_in  <= 1'b0;
  snes_write_n_in  <= 1'b1;
  repeat (LOW_CYCLES) @(posedge CLK2);
  snes_cpu_clk_in <= 1'b1;
  repeat (2) @(posedge CLK2);
  snes_write_n_in <= 1'b0;
  repeat (20) @(posedge CLK2);
  snes_write_n_in <= 1'b1;
  repeat (4) @(posedge CLK2);  // clock stays high past the write strobe
  snes_cpu_clk_in <= 1'b0;
endtask

task automatic hold_clock_low(input int cycles);
  @(posedge CLK2);
  snes_cpu_clk_in <= 1'b0;
  snes_read_n_in  <= 1'b1;
  snes_write_n_in <= 1'b1;
  repeat (cycles) @(posedge CLK2);
endtask

//////////////////////////////////////////////////
// MCU side

// returns on the falling edge after mcu_rdy came back
task automatic wait_mcu_done(input string test);
  int waited;
  waited = 0;
  @(negedge CLK2);
  assert (!mcu_rdy) else begin
    $display("%s: mcu_rdy did not drop after the request", test);
    other_errors++;
  end
  while (!mcu_rdy && waited < MCU_BUDGET) begin
    @(negedge CLK2);
    waited++;
  end
  assert (mcu_rdy) else begin
    $display("%s: mcu_rdy did not return within %0d cycles", test, MCU_BUDGET);
    other_errors++;
  end
endtask

task automatic mcu_write(input string test, input snes_addr_t addr, input byte_t data);
  @(posedge CLK2);
  mcu.wrq   <= 1'b1;
  mcu.addr  <= addr;
  mcu.wdata <= data;
  @(posedge CLK2);
  mcu.wrq <= 1'b0;  // single cycle pulse
  wait_mcu_done(test);
endtask

task automatic mcu_read(input string test, input snes_addr_t addr, output byte_t data);
  @(posedge CLK2);
  mcu.rrq  <= 1'b1;
  mcu.addr <= addr;
  @(posedge CLK2);
  mcu.rrq <= 1'b0;
  wait_mcu_done(test);
  data = mcu_rdata;
endtask

// File: testbench/tb_cart_main.sv
`timescale 1ns/1ps

module tb_cart_main;
  import snes_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int ROM_CYCLE_LEN = 6;
  localparam int DEAD_TIMEOUT  = 200;
  localparam int LOW_CYCLES    = 16;   // cpu clock low phase of one bus cycle
  localparam int MCU_BUDGET    = 100;  // one MCU access including the grant wait

  // worst case cycles per test
  localparam int T_RESET    = 10;
  localparam int T_LOROM    = 4 * 50;
  localparam int T_HIROM    = 5 * 50;
  localparam int T_MCU_RUN  = 4 * 50 + 3 * MCU_BUDGET;
  localparam int T_MCU_DEAD = DEAD_TIMEOUT + 100 + MCU_BUDGET;
  localparam int RUN_LIMIT  = 2 * (T_RESET + T_LOROM + T_HIROM + T_MCU_RUN + T_MCU_DEAD);

  logic        CLK2;
  logic        arst_n;
  snes_addr_t  snes_addr_in;
  byte_t       snes_data_in;
  logic        snes_read_n_in;
  logic        snes_write_n_in;
  logic        snes_cpu_clk_in;
  logic        snes_romsel_n_in;
  byte_t       snes_data_out;
  logic        snes_data_oe;
  logic        snes_databus_oe_n;
  logic        snes_databus_dir;
  mapper_e     mapper;
  snes_addr_t  rom_mask;
  snes_addr_t  saveram_mask;
  mcu_req_t    mcu;
  logic        mcu_rdy;
  byte_t       mcu_rdata;
  logic [22:0] rom_addr;
  logic [15:0] rom_data_in;
  logic [15:0] rom_data_out;
  logic [1:0]  rom_data_oe;
  logic        rom_we_n;
  logic        rom_bhe_n;
  logic        rom_ble_n;

  int          seed = 46;
  int          value_errors = 0;
  int          other_errors = 0;
  logic [31:0] fill_key;
  int          model_rev = 0;
  logic [15:0] written [logic [22:0]];  // PSRAM words changed by writes

  always #(CLK_PERIOD / 2) CLK2 = ~CLK2;

  cart_main #(
    .ROM_CYCLE_LEN (ROM_CYCLE_LEN),
    .DEAD_TIMEOUT  (DEAD_TIMEOUT)
  ) dut0 (
    .CLK2              (CLK2),
    .arst_n            (arst_n),
    .snes_addr_in      (snes_addr_in),
    .snes_data_in      (snes_data_in),
    .snes_read_n_in    (snes_read_n_in),
    .snes_write_n_in   (snes_write_n_in),
    .snes_cpu_clk_in   (snes_cpu_clk_in),
    .snes_romsel_n_in  (snes_romsel_n_in),
    .snes_data_out     (snes_data_out),
    .snes_data_oe      (snes_data_oe),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_databus_dir  (snes_databus_dir),
    .mapper            (mapper),
    .rom_mask          (rom_mask),
    .saveram_mask      (saveram_mask),
    .mcu               (mcu),
    .mcu_rdy           (mcu_rdy),
    .mcu_rdata         (mcu_rdata),
    .rom_addr          (rom_addr),
    .rom_data_in       (rom_data_in),
    .rom_data_out      (rom_data_out),
    .rom_data_oe       (rom_data_oe),
    .rom_we_n          (rom_we_n),
    .rom_bhe_n         (rom_bhe_n),
    .rom_ble_n         (rom_ble_n)
  );

  //////////////////////////////////////////////////
  // PSRAM model

  function automatic logic [15:0] fill_word(input logic [22:0] waddr);
    logic [31:0] mix;
    mix = {9'd0, waddr} * 32'h9E3779B1;
    mix = mix ^ fill_key ^ (mix >> 15);
    return mix[15:0] ^ mix[31:16];
  endfunction

  function automatic logic [15:0] model_word(input logic [22:0] waddr);
    if (written.exists(waddr)) return written[waddr];
    return fill_word(waddr);
  endfunction

  // bit 0 set selects the low lane
  function automatic byte_t model_byte(input snes_addr_t a);
    logic [15:0] w;
    w = model_word(a[23:1]);
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  always @(rom_addr or model_rev) begin
    rom_data_in = model_word(rom_addr);
  end

  always @(posedge CLK2) begin : psram_write
    logic [15:0] new_word;
    if (arst_n && !rom_we_n) begin
      new_word = model_word(rom_addr);
      if (!rom_ble_n && rom_data_oe[0]) new_word[7:0] = rom_data_out[7:0];
      if (!rom_bhe_n && rom_data_oe[1]) new_word[15:8] = rom_data_out[15:8];
      written[rom_addr] = new_word;
      model_rev = model_rev + 1;
    end
  end

  //////////////////////////////////////////////////
  // mapping rules

  // 32k page per bank
  function automatic snes_addr_t lorom_rom(input snes_addr_t a, input snes_addr_t mask);
    snes_addr_t bank;
    bank = snes_addr_t'(a[22:16]);
    return ((bank << 15) | (a & 24'h007FFF)) & mask;
  endfunction

  function automatic snes_addr_t hirom_rom(input snes_addr_t a, input snes_addr_t mask);
    return a & 24'h3FFFFF & mask;
  endfunction

  // 8k save RAM page per bank
  function automatic snes_addr_t hirom_sram(input snes_addr_t a, input snes_addr_t mask);
    snes_addr_t bank;
    bank = snes_addr_t'(a[20:16]);
    return SAVERAM_BASE + (((bank << 13) | (a & 24'h001FFF)) & mask);
  endfunction

  `include "tb_tasks.svh"

  //////////////////////////////////////////////////
  // tests

  task automatic test_reset();
    @(negedge CLK2);
    check_value("reset mcu_rdy", 1, mcu_rdy);
    check_value("reset rom_we_n", 1, rom_we_n);
    check_value("reset rom_data_oe", 0, rom_data_oe);
    check_value("reset snes_data_oe", 0, snes_data_oe);
    check_value("reset snes_databus_oe_n", 1, snes_databus_oe_n);
    check_value("reset snes_databus_dir", 0, snes_databus_dir);
  endtask

  task automatic test_lorom_reads();
    snes_addr_t addrs [4];
    addrs = '{24'h008000, 24'h01FFFF, 24'h8A9C35, 24'h3F8001};
    foreach (addrs[i]) begin
      snes_read("lorom read", addrs[i], model_byte(lorom_rom(addrs[i], rom_mask)));
    end
  endtask

  task automatic test_hirom_saveram();
    snes_addr_t addrs [3];
    snes_addr_t sram_addr;
    addrs = '{24'hC12345, 24'h40FFFE, 24'h00F00F};
    sram_addr = 24'h2A6155;  // bank 2a inside the 6000-7fff window
    @(posedge CLK2);
    mapper   <= MAP_HIROM;
    rom_mask <= 24'h0FFFFF;  // 1 MB image
    @(posedge CLK2);
    foreach (addrs[i]) begin
      snes_read("hirom read", addrs[i], model_byte(hirom_rom(addrs[i], rom_mask)));
    end
    snes_write("saveram write", sram_addr, 8'hA5);
    check_value("saveram write", 8'hA5, model_byte(hirom_sram(sram_addr, saveram_mask)));
    snes_read("saveram read", sram_addr, 8'hA5);
  endtask

  task automatic test_mcu_running();
    snes_addr_t addrs [4];
    snes_addr_t maddr;
    snes_addr_t other;
    byte_t      wbyte;
    byte_t      rbyte;
    byte_t      obyte;
    byte_t      other_expected;
    addrs = '{24'h00C000, 24'h059FF1, 24'h12F00E, 24'h7E8003};
    maddr = 24'h123457;
    other = maddr ^ 24'h000001;  // high lane of the same PSRAM word
    wbyte = 8'h3C;
    other_expected = model_byte(other);
    @(posedge CLK2);
    mapper   <= MAP_LOROM;
    rom_mask <= 24'h3FFFFF;
    fork
      begin
        mcu_write("mcu write running", maddr, wbyte);
        mcu_read("mcu read other lane", other, obyte);
        mcu_read("mcu read running", maddr, rbyte);
      end
      begin
        foreach (addrs[i]) begin
          snes_read("read beside mcu", addrs[i], model_byte(lorom_rom(addrs[i], rom_mask)));
        end
      end
    join
    check_value("mcu read other lane", other_expected, obyte);
    check_value("mcu read running", wbyte, rbyte);
    check_value("mcu write model", wbyte, model_byte(maddr));
  endtask

  task automatic test_mcu_dead();
    snes_addr_t maddr;
    byte_t      expected;
    byte_t      rbyte;
    hold_clock_low(DEAD_TIMEOUT + 50);
    maddr    = snes_addr_t'($random(seed));
    expected = model_byte(maddr);
    mcu_read("mcu read dead", maddr, rbyte);
    check_value("mcu read dead", expected, rbyte);
    snes_read("read after revival", 24'h028123, model_byte(lorom_rom(24'h028123, rom_mask)));
  endtask

  //////////////////////////////////////////////////
  // sequence and watchdog

  initial begin
    CLK2             = 1'b0;
    arst_n           = 1'b0;
    snes_addr_in     = '0;
    snes_data_in     = '0;
    snes_read_n_in   = 1'b1;
    snes_write_n_in  = 1'b1;
    snes_cpu_clk_in  = 1'b0;
    snes_romsel_n_in = 1'b1;
    mapper           = MAP_LOROM;
    rom_mask         = 24'h3FFFFF;
    saveram_mask     = 24'h007FFF;
    mcu              = '0;
    fill_key         = $random(seed);
    model_rev        = model_rev + 1;
    repeat (4) @(posedge CLK2);
    arst_n <= 1'b1;
    test_reset();
    test_lorom_reads();
    test_hirom_saveram();
    test_mcu_running();
    test_mcu_dead();
    repeat (4) @(posedge CLK2);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(RUN_LIMIT * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not finish", RUN_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+testbench
design/snes_pkg.sv
design/sample_pipe.sv
design/snes_bus_sync.sv
design/rom_map.sv
design/snes_liveness.sv
design/mem_arbiter.sv
design/rom_port.sv
design/cart_main.sv
testbench/tb_cart_main.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cart_main
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
